// File: verilog/axi_ram_macros.svh
// width and depth macros for the AXI RAM; include before using the package types or testbench
`ifndef AXI_RAM_MACROS_SVH
`define AXI_RAM_MACROS_SVH

// byte address width
`define AXI_RAM_ADDR_W 32

// data bus width, one RAM word per beat
`define AXI_RAM_DATA_W 64

// transaction id width
`define AXI_RAM_ID_W 4

// 1024 words, 8 KiB
`define AXI_RAM_DEPTH_LOG2 10

`endif

// File: verilog/axi_ram_pkg.sv
// shared types, response codes, FSM states and address helpers for the AXI RAM
package axi_ram_pkg;
    `include "axi_ram_macros.svh"

    localparam int OFFS_W = $clog2(`AXI_RAM_DATA_W / 8);
    localparam int DEPTH_LOG2 = `AXI_RAM_DEPTH_LOG2;

    typedef logic [`AXI_RAM_ADDR_W-1:0]   addr_t;
    typedef logic [`AXI_RAM_DATA_W-1:0]   data_t;
    typedef logic [`AXI_RAM_DATA_W/8-1:0] strb_t;
    typedef logic [`AXI_RAM_ID_W-1:0]     id_t;
    typedef logic [7:0]                   len_t;
    typedef logic [2:0]                   size_t;
    typedef logic [1:0]                   burst_t;
    typedef logic [1:0]                   resp_t;
    typedef logic [DEPTH_LOG2-1:0]        word_addr_t;

    localparam resp_t RESP_OKAY = 2'b00;
    localparam resp_t RESP_DECERR = 2'b11;
    localparam burst_t BURST_FIXED = 2'b00;

    typedef enum logic [1:0] {RD_IDLE, RD_FETCH, RD_DATA} rd_state_e;
    typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_e;

    // wrap bursts fall through to incr
    function automatic addr_t step_addr(addr_t addr, size_t size, burst_t burst);
        if (burst == BURST_FIXED) begin
            return addr;
        end
        return addr + (addr_t'(1) << size);
    endfunction

    function automatic logic addr_in_range(addr_t addr);
        return (addr >> (OFFS_W + DEPTH_LOG2)) == '0;
    endfunction

    function automatic word_addr_t word_index(addr_t addr);
        return addr[OFFS_W +: DEPTH_LOG2];
    endfunction
endpackage

// File: verilog/mem_wr_if.sv
// RAM write port bundle; the write engine drives it and the RAM bank samples it
interface mem_wr_if;
    import axi_ram_pkg::*;

    // write strobe for this cycle
    logic       en;
    word_addr_t addr;
    data_t      data;
    // one enable per byte lane
    strb_t      strb;

    modport engine (
        output en,
        output addr,
        output data,
        output strb
    );

    modport mem (
        input en,
        input addr,
        input data,
        input strb
    );
endinterface

// File: verilog/ram_bank.sv
// byte-strobed synchronous RAM with one registered read port and one write port
module ram_bank (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_rd_en,
    input  axi_ram_pkg::word_addr_t i_rd_addr,
    output axi_ram_pkg::data_t      o_rd_data,
    mem_wr_if.mem                   wr
);
    import axi_ram_pkg::*;

    localparam int DEPTH = 1 << $bits(word_addr_t);
    localparam int NUM_BYTES = $bits(strb_t);

    data_t mem [0:DEPTH-1];

    // byte lanes written independently
    always_ff @(posedge clk) begin
        if (wr.en) begin
            for (int i = 0; i < NUM_BYTES; i++) begin
                if (wr.strb[i]) begin
                    mem[wr.addr][i*8 +: 8] <= wr.data[i*8 +: 8];
                end
            end
        end
    end

    // old contents win on a same-word collision
    always_ff @(posedge clk) begin
        if (rst) begin
            o_rd_data <= '0;
        end else if (i_rd_en) begin
            o_rd_data <= mem[i_rd_addr];
        end
    end
endmodule

// File: verilog/axi_rd_engine.sv
// AXI4 read channel engine; takes one AR burst at a time and streams R beats from the RAM
module axi_rd_engine (
    input  logic                    clk,
    input  logic                    rst,

    // ar
    input  logic                    i_arvalid,
    output logic                    o_arready,
    input  axi_ram_pkg::addr_t      i_araddr,
    input  axi_ram_pkg::id_t        i_arid,
    input  axi_ram_pkg::len_t       i_arlen,
    input  axi_ram_pkg::size_t      i_arsize,
    input  axi_ram_pkg::burst_t     i_arburst,

    // r
    input  logic                    i_rready,
    output logic                    o_rvalid,
    output logic                    o_rlast,
    output axi_ram_pkg::resp_t      o_rresp,
    output axi_ram_pkg::data_t      o_rdata,
    output axi_ram_pkg::id_t        o_rid,

    // ram read port
    output logic                    o_mem_rd_en,
    output axi_ram_pkg::word_addr_t o_mem_rd_addr,
    input  axi_ram_pkg::data_t      i_mem_rd_data
);
    import axi_ram_pkg::*;

    rd_state_e state;

    // captured request
    addr_t  cur_addr;
    id_t    cur_id;
    len_t   cur_len;
    size_t  cur_size;
    burst_t cur_burst;

    len_t   beat_cnt;
    // ram read already in flight for this beat
    logic   issued;

    logic   ar_hs;
    logic   r_hs;
    logic   beat_ok;
    addr_t  next_addr;

    assign ar_hs = i_arvalid && o_arready;
    assign r_hs = o_rvalid && i_rready;
    assign next_addr = step_addr(cur_addr, cur_size, cur_burst);
    assign beat_ok = addr_in_range(cur_addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RD_IDLE;
            beat_cnt <= '0;
            issued <= 1'b0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (ar_hs) begin
                        state <= RD_FETCH;
                        beat_cnt <= '0;
                        issued <= 1'b0;
                    end
                end
                RD_FETCH: begin
                    // first beat issues here, later beats at the R handshake
                    if (issued) begin
                        state <= RD_DATA;
                    end else begin
                        issued <= 1'b1;
                    end
                end
                RD_DATA: begin
                    if (r_hs) begin
                        if (o_rlast) begin
                            state <= RD_IDLE;
                        end else begin
                            state <= RD_FETCH;
                            beat_cnt <= beat_cnt + 8'd1;
                            issued <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= RD_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            cur_addr <= i_araddr;
            cur_id <= i_arid;
            cur_len <= i_arlen;
            cur_size <= i_arsize;
            cur_burst <= i_arburst;
        end else if (r_hs) begin
            cur_addr <= next_addr;
        end
    end

    // next beat is fetched on the edge its predecessor transfers
    assign o_mem_rd_en = (state == RD_FETCH && !issued) || (r_hs && !o_rlast);
    assign o_mem_rd_addr = (state == RD_DATA) ? word_index(next_addr) : word_index(cur_addr);

    assign o_arready = (state == RD_IDLE);
    assign o_rvalid = (state == RD_DATA);
    assign o_rlast = (beat_cnt == cur_len);
    assign o_rresp = beat_ok ? RESP_OKAY : RESP_DECERR;
    // out-of-range beats read as zero
    assign o_rdata = beat_ok ? i_mem_rd_data : '0;
    assign o_rid = cur_id;
endmodule

// File: verilog/axi_wr_engine.sv
// AXI4 write channel engine; takes one AW burst at a time, writes W beats and returns B
module axi_wr_engine (
    input  logic                clk,
    input  logic                rst,

    // aw
    input  logic                i_awvalid,
    output logic                o_awready,
    input  axi_ram_pkg::addr_t  i_awaddr,
    input  axi_ram_pkg::id_t    i_awid,
    input  axi_ram_pkg::len_t   i_awlen,
    input  axi_ram_pkg::size_t  i_awsize,
    input  axi_ram_pkg::burst_t i_awburst,

    // w
    input  logic                i_wvalid,
    output logic                o_wready,
    input  axi_ram_pkg::data_t  i_wdata,
    input  axi_ram_pkg::strb_t  i_wstrb,
    // burst end comes from the beat counter, wlast is not checked
    input  logic                i_wlast,

    // b
    input  logic                i_bready,
    output logic                o_bvalid,
    output axi_ram_pkg::resp_t  o_bresp,
    output axi_ram_pkg::id_t    o_bid,

    mem_wr_if.engine            wr
);
    import axi_ram_pkg::*;

    wr_state_e state;

    addr_t  cur_addr;
    id_t    cur_id;
    len_t   cur_len;
    size_t  cur_size;
    burst_t cur_burst;

    len_t   beat_cnt;
    // some beat of this burst fell outside the RAM
    logic   range_err;

    logic   aw_hs;
    logic   w_hs;
    logic   b_hs;
    logic   beat_ok;

    assign aw_hs = i_awvalid && o_awready;
    assign w_hs = i_wvalid && o_wready;
    assign b_hs = o_bvalid && i_bready;
    assign beat_ok = addr_in_range(cur_addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= WR_IDLE;
            beat_cnt <= '0;
            range_err <= 1'b0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (aw_hs) begin
                        state <= WR_DATA;
                        beat_cnt <= '0;
                        range_err <= 1'b0;
                    end
                end
                WR_DATA: begin
                    if (w_hs) begin
                        range_err <= range_err || !beat_ok;
                        if (beat_cnt == cur_len) begin
                            state <= WR_RESP;
                        end else begin
                            beat_cnt <= beat_cnt + 8'd1;
                        end
                    end
                end
                WR_RESP: begin
                    if (b_hs) begin
                        state <= WR_IDLE;
                    end
                end
                default: begin
                    state <= WR_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            cur_addr <= i_awaddr;
            cur_id <= i_awid;
            cur_len <= i_awlen;
            cur_size <= i_awsize;
            cur_burst <= i_awburst;
        end else if (w_hs) begin
            cur_addr <= step_addr(cur_addr, cur_size, cur_burst);
        end
    end

    // out-of-range beats are dropped
    assign wr.en = w_hs && beat_ok;
    assign wr.addr = word_index(cur_addr);
    assign wr.data = i_wdata;
    assign wr.strb = i_wstrb;

    assign o_awready = (state == WR_IDLE);
    assign o_wready = (state == WR_DATA);
    assign o_bvalid = (state == WR_RESP);
    assign o_bresp = range_err ? RESP_DECERR : RESP_OKAY;
    assign o_bid = cur_id;
endmodule

// File: verilog/axi_ram.sv
// AXI4 subordinate RAM top level; 8 KiB at address zero, read and write engines run in parallel
module axi_ram (
    input  logic                clk,
    input  logic                rst,

    // ar
    output logic                o_axi_slave_arready,
    input  logic                i_axi_slave_arvalid,
    input  axi_ram_pkg::addr_t  i_axi_slave_araddr,
    input  axi_ram_pkg::id_t    i_axi_slave_arid,
    input  axi_ram_pkg::len_t   i_axi_slave_arlen,
    input  axi_ram_pkg::size_t  i_axi_slave_arsize,
    input  axi_ram_pkg::burst_t i_axi_slave_arburst,

    // r
    input  logic                i_axi_slave_rready,
    output logic                o_axi_slave_rvalid,
    output logic                o_axi_slave_rlast,
    output axi_ram_pkg::resp_t  o_axi_slave_rresp,
    output axi_ram_pkg::data_t  o_axi_slave_rdata,
    output axi_ram_pkg::id_t    o_axi_slave_rid,

    // aw
    output logic                o_axi_slave_awready,
    input  logic                i_axi_slave_awvalid,
    input  axi_ram_pkg::addr_t  i_axi_slave_awaddr,
    input  axi_ram_pkg::id_t    i_axi_slave_awid,
    input  axi_ram_pkg::len_t   i_axi_slave_awlen,
    input  axi_ram_pkg::size_t  i_axi_slave_awsize,
    input  axi_ram_pkg::burst_t i_axi_slave_awburst,

    // w
    output logic                o_axi_slave_wready,
    input  logic                i_axi_slave_wvalid,
    input  axi_ram_pkg::data_t  i_axi_slave_wdata,
    input  axi_ram_pkg::strb_t  i_axi_slave_wstrb,
    input  logic                i_axi_slave_wlast,

    // b
    input  logic                i_axi_slave_bready,
    output logic                o_axi_slave_bvalid,
    output axi_ram_pkg::resp_t  o_axi_slave_bresp,
    output axi_ram_pkg::id_t    o_axi_slave_bid
);
    import axi_ram_pkg::*;

    logic       mem_rd_en;
    word_addr_t mem_rd_addr;
    data_t      mem_rd_data;

    mem_wr_if u_mem_wr ();

    axi_rd_engine u_rd_engine (
        .clk           (clk),
        .rst           (rst),
        .i_arvalid     (i_axi_slave_arvalid),
        .o_arready     (o_axi_slave_arready),
        .i_araddr      (i_axi_slave_araddr),
        .i_arid        (i_axi_slave_arid),
        .i_arlen       (i_axi_slave_arlen),
        .i_arsize      (i_axi_slave_arsize),
        .i_arburst     (i_axi_slave_arburst),
        .i_rready      (i_axi_slave_rready),
        .o_rvalid      (o_axi_slave_rvalid),
        .o_rlast       (o_axi_slave_rlast),
        .o_rresp       (o_axi_slave_rresp),
        .o_rdata       (o_axi_slave_rdata),
        .o_rid         (o_axi_slave_rid),
        .o_mem_rd_en   (mem_rd_en),
        .o_mem_rd_addr (mem_rd_addr),
        .i_mem_rd_data (mem_rd_data)
    );

    axi_wr_engine u_wr_engine (
        .clk       (clk),
        .rst       (rst),
        .i_awvalid (i_axi_slave_awvalid),
        .o_awready (o_axi_slave_awready),
        .i_awaddr  (i_axi_slave_awaddr),
        .i_awid    (i_axi_slave_awid),
        .i_awlen   (i_axi_slave_awlen),
        .i_awsize  (i_axi_slave_awsize),
        .i_awburst (i_axi_slave_awburst),
        .i_wvalid  (i_axi_slave_wvalid),
        .o_wready  (o_axi_slave_wready),
        .i_wdata   (i_axi_slave_wdata),
        .i_wstrb   (i_axi_slave_wstrb),
        .i_wlast   (i_axi_slave_wlast),
        .i_bready  (i_axi_slave_bready),
        .o_bvalid  (o_axi_slave_bvalid),
        .o_bresp   (o_axi_slave_bresp),
        .o_bid     (o_axi_slave_bid),
        .wr        (u_mem_wr.engine)
    );

    ram_bank u_ram (
        .clk       (clk),
        .rst       (rst),
        .i_rd_en   (mem_rd_en),
        .i_rd_addr (mem_rd_addr),
        .o_rd_data (mem_rd_data),
        .wr        (u_mem_wr.mem)
    );
endmodule

// File: dv/axi_ram_tb.sv
// testbench for the AXI RAM; runs a table of bursts against a byte-level model of the memory
`include "axi_ram_macros.svh"

module axi_ram_tb;
    import axi_ram_pkg::*;

    localparam int RAM_BYTES = (`AXI_RAM_DATA_W / 8) << `AXI_RAM_DEPTH_LOG2;
    localparam int TIMEOUT = 200;
    localparam int OP_WR = 0;
    localparam int OP_RD = 1;
    localparam int OP_RW = 2;

    typedef struct packed {
        logic [1:0]  op;
        addr_t       addr;
        len_t        len;
        size_t       size;
        burst_t      burst;
        id_t         id;
        strb_t       strb;
        logic [31:0] seed;
        logic [7:0]  stall;
    } entry_t;

    logic clk;
    logic rst;
    logic arvalid, rready, awvalid, wvalid, wlast, bready;
    addr_t araddr, awaddr;
    id_t arid, awid;
    len_t arlen, awlen;
    size_t arsize, awsize;
    burst_t arburst, awburst;
    data_t wdata;
    strb_t wstrb;
    logic o_arready, o_rvalid, o_rlast, o_awready, o_wready, o_bvalid;
    resp_t o_rresp, o_bresp;
    data_t o_rdata;
    id_t o_rid, o_bid;

    logic [7:0] model [0:RAM_BYTES-1];
    entry_t steps[$];
    int err_count;
    int pass_tests;
    int fail_tests;
    bit hung;

    axi_ram UUT (
        .clk(clk), .rst(rst),
        .o_axi_slave_arready(o_arready), .i_axi_slave_arvalid(arvalid),
        .i_axi_slave_araddr(araddr), .i_axi_slave_arid(arid), .i_axi_slave_arlen(arlen),
        .i_axi_slave_arsize(arsize), .i_axi_slave_arburst(arburst),
        .i_axi_slave_rready(rready), .o_axi_slave_rvalid(o_rvalid),
        .o_axi_slave_rlast(o_rlast), .o_axi_slave_rresp(o_rresp),
        .o_axi_slave_rdata(o_rdata), .o_axi_slave_rid(o_rid),
        .o_axi_slave_awready(o_awready), .i_axi_slave_awvalid(awvalid),
        .i_axi_slave_awaddr(awaddr), .i_axi_slave_awid(awid), .i_axi_slave_awlen(awlen),
        .i_axi_slave_awsize(awsize), .i_axi_slave_awburst(awburst),
        .o_axi_slave_wready(o_wready), .i_axi_slave_wvalid(wvalid),
        .i_axi_slave_wdata(wdata), .i_axi_slave_wstrb(wstrb), .i_axi_slave_wlast(wlast),
        .i_axi_slave_bready(bready), .o_axi_slave_bvalid(o_bvalid),
        .o_axi_slave_bresp(o_bresp), .o_axi_slave_bid(o_bid)
    );

    always #20 clk = ~clk;

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    // one cycle of a handshake wait
    task automatic tick_wait(input string chan, inout int cycles);
        @(negedge clk);
        cycles++;
        if (cycles > TIMEOUT && !hung) begin
            $display("timeout: the %s handshake never completed, time %0t", chan, $time);
            hung = 1'b1;
            err_count++;
        end
    endtask

    function automatic logic in_ram(addr_t a);
        return a < RAM_BYTES;
    endfunction

    function automatic data_t model_word(addr_t a);
        data_t w;
        for (int i = 0; i < 8; i++) begin
            w[i*8 +: 8] = model[(a & ~addr_t'(7)) + i];
        end
        return w;
    endfunction

    // fixed stays put while incr and wrap step by the beat size
    function automatic addr_t next_beat(addr_t a, size_t size, burst_t burst);
        if (burst == BURST_FIXED) begin
            return a;
        end
        return a + (addr_t'(1) << size);
    endfunction

    function automatic strb_t rotate_strb(strb_t pat, int beat);
        int sh;
        sh = beat % 8;
        return strb_t'(pat << sh) | strb_t'(pat >> (8 - sh));
    endfunction

    function automatic data_t beat_data(logic [31:0] seed, int beat);
        return {seed + 32'(beat) * 32'h01010101, ~seed ^ 32'(beat)};
    endfunction

    task automatic do_write(input addr_t addr, input len_t len, input size_t size,
                            input burst_t burst, input id_t id, input strb_t pat,
                            input logic [31:0] seed, input int stall);
        addr_t a;
        strb_t s;
        data_t d;
        resp_t exp_resp;
        int cycles;
        int delay;
        exp_resp = RESP_OKAY;
        awaddr = addr;
        awlen = len;
        awsize = size;
        awburst = burst;
        awid = id;
        awvalid = 1'b1;
        cycles = 0;
        while (!o_awready && !hung) tick_wait("AW", cycles);
        @(negedge clk);
        awvalid = 1'b0;
        a = addr;
        for (int beat = 0; beat <= len && !hung; beat++) begin
            delay = 0;
            while (delay < 8 && $urandom_range(99) < stall) begin
                @(negedge clk);
                delay++;
            end
            s = rotate_strb(pat, beat);
            d = beat_data(seed, beat);
            wdata = d;
            wstrb = s;
            wlast = (beat == len);
            wvalid = 1'b1;
            cycles = 0;
            while (!o_wready && !hung) tick_wait("W", cycles);
            // beat lands at the coming rising edge
            if (in_ram(a)) begin
                for (int i = 0; i < 8; i++) begin
                    if (s[i]) model[(a & ~addr_t'(7)) + i] = d[i*8 +: 8];
                end
            end else begin
                exp_resp = RESP_DECERR;
            end
            @(negedge clk);
            wvalid = 1'b0;
            wlast = 1'b0;
            a = next_beat(a, size, burst);
        end
        if (!hung) check("wready after last beat", o_wready, 1'b0);
        bready = ($urandom_range(99) >= stall);
        cycles = 0;
        while (!(o_bvalid && bready) && !hung) begin
            tick_wait("B", cycles);
            bready = ($urandom_range(99) >= stall);
        end
        if (!hung) begin
            check("bresp", o_bresp, exp_resp);
            check("bid", o_bid, id);
        end
        @(negedge clk);
        bready = 1'b0;
        // a second response or a busy engine shows up here
        if (!hung) begin
            check("bvalid after B", o_bvalid, 1'b0);
            check("awready after B", o_awready, 1'b1);
        end
    endtask

    task automatic do_read(input addr_t addr, input len_t len, input size_t size,
                           input burst_t burst, input id_t id, input int stall);
        addr_t a;
        int cycles;
        araddr = addr;
        arlen = len;
        arsize = size;
        arburst = burst;
        arid = id;
        arvalid = 1'b1;
        cycles = 0;
        while (!o_arready && !hung) tick_wait("AR", cycles);
        @(negedge clk);
        arvalid = 1'b0;
        a = addr;
        for (int beat = 0; beat <= len && !hung; beat++) begin
            rready = ($urandom_range(99) >= stall);
            cycles = 0;
            while (!(o_rvalid && rready) && !hung) begin
                tick_wait("R", cycles);
                rready = ($urandom_range(99) >= stall);
            end
            if (!hung) begin
                check("rdata", o_rdata, in_ram(a) ? model_word(a) : data_t'(0));
                check("rresp", o_rresp, in_ram(a) ? RESP_OKAY : RESP_DECERR);
                check("rlast", o_rlast, beat == len);
                check("rid", o_rid, id);
            end
            @(negedge clk);
            rready = 1'b0;
            a = next_beat(a, size, burst);
        end
        // a pending extra beat keeps the engine busy
        if (!hung) begin
            check("rvalid after rlast", o_rvalid, 1'b0);
            check("arready after rlast", o_arready, 1'b1);
        end
    endtask

    task automatic add_step(input int op, input addr_t addr, input len_t len, input size_t size,
                            input burst_t burst, input id_t id, input strb_t strb,
                            input logic [31:0] seed, input int stall);
        steps.push_back({op[1:0], addr, len, size, burst, id, strb, seed, stall[7:0]});
    endtask

    task automatic report_test(input int num, input string desc, input int start_err);
        if (err_count == start_err) begin
            pass_tests++;
            $display("test %0d %s: ok", num, desc);
        end else begin
            fail_tests++;
            $display("test %0d %s: %0d mismatches", num, desc, err_count - start_err);
        end
    endtask

    initial begin
        entry_t e;
        int start_err;
        void'($urandom(32'h5f44));
        clk = 1'b0;
        rst = 1'b1;
        {arvalid, rready, awvalid, wvalid, wlast, bready} = '0;
        {araddr, arid, arlen, arsize, arburst} = '0;
        {awaddr, awid, awlen, awsize, awburst} = '0;
        wdata = '0;
        wstrb = '0;
        err_count = 0;
        pass_tests = 0;
        fail_tests = 0;
        hung = 1'b0;

        // op, addr, len, size, burst, id, strobes, data seed, stall percent
        add_step(OP_WR, 32'h0000, 7, 3, 2'b01, 1, 8'hff, 32'h11110000, 0);
        add_step(OP_RD, 32'h0000, 7, 3, 2'b01, 2, 8'h00, 0, 0);
        add_step(OP_WR, 32'h0010, 3, 3, 2'b01, 3, 8'h0f, 32'h2222a5a5, 0);
        add_step(OP_RD, 32'h0000, 7, 3, 2'b01, 4, 8'h00, 0, 0);
        add_step(OP_WR, 32'h0100, 7, 3, 2'b00, 5, 8'h01, 32'h3333c3c3, 0);
        add_step(OP_RD, 32'h0100, 3, 3, 2'b00, 6, 8'h00, 0, 0);
        // crosses the top of the 8 KiB map
        add_step(OP_WR, 32'h1fe0, 7, 3, 2'b01, 7, 8'hff, 32'h44440f0f, 0);
        add_step(OP_RD, 32'h1fe0, 7, 3, 2'b01, 8, 8'h00, 0, 0);
        add_step(OP_RD, 32'h0000, 3, 3, 2'b01, 9, 8'h00, 0, 0);
        add_step(OP_WR, 32'h0200, 15, 3, 2'b01, 10, 8'hff, 32'h55551234, 50);
        add_step(OP_RD, 32'h0200, 15, 3, 2'b01, 11, 8'h00, 0, 50);
        // wrap runs as incr in 4-byte steps
        add_step(OP_WR, 32'h0400, 15, 2, 2'b10, 12, 8'hff, 32'h66669876, 30);
        add_step(OP_RD, 32'h0400, 15, 2, 2'b01, 13, 8'h00, 0, 30);
        // write here while reading 1 KiB below
        add_step(OP_RW, 32'h0600, 7, 3, 2'b01, 14, 8'hff, 32'h7777beef, 20);
        add_step(OP_RD, 32'h0600, 7, 3, 2'b01, 15, 8'h00, 0, 20);

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start_err = err_count;
        check("arready after reset", o_arready, 1'b1);
        check("awready after reset", o_awready, 1'b1);
        check("rvalid after reset", o_rvalid, 1'b0);
        check("wready after reset", o_wready, 1'b0);
        check("bvalid after reset", o_bvalid, 1'b0);
        report_test(0, "reset values", start_err);

        for (int t = 0; t < steps.size() && !hung; t++) begin
            e = steps[t];
            start_err = err_count;
            case (e.op)
                OP_WR: do_write(e.addr, e.len, e.size, e.burst, e.id, e.strb, e.seed, e.stall);
                OP_RD: do_read(e.addr, e.len, e.size, e.burst, e.id, e.stall);
                default: begin
                    fork
                        do_write(e.addr, e.len, e.size, e.burst, e.id, e.strb, e.seed, e.stall);
                        do_read(e.addr - 32'h400, e.len, e.size, e.burst, e.id + 1, e.stall);
                    join
                end
            endcase
            report_test(t + 1, $sformatf("op %0d at %h, %0d beats", e.op, e.addr, e.len + 1),
                        start_err);
        end

        $display("tests: %0d passed, %0d failed, %0d mismatches",
                 pass_tests, fail_tests, err_count);
        if (err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end
endmodule

// File: axi_ram.f
+incdir+verilog
verilog/axi_ram_pkg.sv
verilog/mem_wr_if.sv
verilog/ram_bank.sv
verilog/axi_rd_engine.sv
verilog/axi_wr_engine.sv
verilog/axi_ram.sv
dv/axi_ram_tb.sv

// File: Bender.yml
package:
  name: axi_ram

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/axi_ram_pkg.sv
      - verilog/mem_wr_if.sv
      - verilog/ram_bank.sv
      - verilog/axi_rd_engine.sv
      - verilog/axi_wr_engine.sv
      - verilog/axi_ram.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/axi_ram_tb.sv
